//--- rtl/spmv_pkg.sv
`default_nettype none

package spmv_pkg;

    localparam int addr_w = 48;
    localparam int data_w = 64;

    typedef logic [1:0] reg_idx_t;

    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_RST    = 3'd1,
        OP_STEADY = 3'd2,
        OP_LD     = 3'd3,
        OP_READ   = 3'd4,
        OP_RETURN = 3'd5
    } opcode_t;

    // ring word, top bit first
    typedef struct packed {
        logic [51:0] data;
        logic [3:0]  reg_idx;
        logic        broadcast;
        logic [3:0]  pe_id;
        opcode_t     opcode;
    } ring_op_t;

    // r0 result addr, r1 entry base, r2 x base, r3 nonzero count
    typedef struct packed {
        logic [addr_w-1:0] r3;
        logic [addr_w-1:0] r2;
        logic [addr_w-1:0] r1;
        logic [addr_w-1:0] r0;
    } pe_regs_t;

    typedef struct packed {
        logic [31:0] value;
        logic [31:0] col;
    } entry_t;

    typedef enum logic {
        RUN_IDLE,
        RUN_ACTIVE
    } run_state_t;

endpackage

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // tag bit 0 picks the response consumer
    typedef logic [2:0] mem_tag_t;

    localparam int       tag_x_bit = 0;
    localparam mem_tag_t tag_entry = 3'd0;
    localparam mem_tag_t tag_x     = 3'd1;

    typedef struct packed {
        logic                       ld;
        logic                       st;
        logic [spmv_pkg::addr_w-1:0] addr;
        logic [spmv_pkg::data_w-1:0] d_or_tag;
    } mem_req_t;

    typedef struct packed {
        logic                       push;
        mem_tag_t                   tag;
        logic [spmv_pkg::data_w-1:0] q;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        SRC_NONE,
        SRC_STORE,
        SRC_X,
        SRC_ENTRY
    } req_src_t;

    localparam int queue_depth       = 32;
    localparam int queue_almost_full = 4;

endpackage

`default_nettype wire

//--- rtl/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
    parameter int width             = 64,
    parameter int depth             = 32,
    parameter int almost_full_count = 4
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              push,
    input  wire              pop,
    input  wire [width-1:0]  d,
    output logic [width-1:0] q,
    output logic             full,
    output logic             empty,
    output logic             almost_full
);

    localparam int ptr_w = $clog2(depth);
    localparam logic [ptr_w:0] full_level = (ptr_w + 1)'(depth);
    localparam logic [ptr_w:0] af_level = (ptr_w + 1)'(depth - almost_full_count);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // read data lands one cycle after pop
    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= d;
        if (do_pop)
            q <= mem[rd_ptr];
    end

    assign full = count == full_level;
    assign empty = count == '0;
    assign almost_full = count >= af_level;

endmodule

`default_nettype wire

//--- rtl/op_ring_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module op_ring_ctrl
    import spmv_pkg::*;
#(
    parameter logic [3:0] pe_id = 4'd0
) (
    input  wire           clk,
    input  wire           reset,
    input  wire ring_op_t op_in,
    output ring_op_t      op_out,
    input  wire           busy_in,
    output logic          busy_out,
    output pe_regs_t      regs,
    output logic          run_start,
    input  wire           run_done
);

    ring_op_t   op_in_r;
    ring_op_t   op_r;
    ring_op_t   next_op_out;
    logic       busy_in_r;
    logic       hit;
    reg_idx_t   idx;
    run_state_t run_state;

    // decode stage acts on broadcast ops and ops for this id
    assign hit = op_r.broadcast || (op_r.pe_id == pe_id);
    assign idx = op_r.reg_idx[1:0];

    // a read for us takes the slot of the op passing through
    always_comb begin
        next_op_out = op_in_r;
        if (hit && op_r.opcode == OP_READ) begin
            next_op_out.opcode    = OP_RETURN;
            next_op_out.pe_id     = pe_id;
            next_op_out.broadcast = 1'b0;
            next_op_out.reg_idx   = op_r.reg_idx;
            next_op_out.data      = {4'd0, regs[idx*addr_w +: addr_w]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_in_r   <= '0;
            op_r      <= '0;
            op_out    <= '0;
            busy_in_r <= 1'b0;
            busy_out  <= 1'b0;
        end else begin
            op_in_r   <= op_in;
            op_r      <= op_in_r;
            op_out    <= next_op_out;
            busy_in_r <= busy_in;
            busy_out  <= busy_in_r || (run_state == RUN_ACTIVE);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs      <= '0;
            run_state <= RUN_IDLE;
            run_start <= 1'b0;
        end else begin
            run_start <= 1'b0;
            if (run_done)
                run_state <= RUN_IDLE;
            if (hit) begin
                case (op_r.opcode)
                    OP_RST: begin
                        regs      <= '0;
                        run_state <= RUN_IDLE;
                    end
                    OP_LD: regs[idx*addr_w +: addr_w] <= op_r.data[addr_w-1:0];
                    OP_STEADY: begin
                        run_start <= 1'b1;
                        run_state <= RUN_ACTIVE;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/entry_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module entry_fetch
    import spmv_pkg::*;
    import mem_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire           run_start,
    input  wire pe_regs_t regs,
    output mem_req_t      entry_req,
    input  wire           req_full,
    input  wire mem_rsp_t entry_rsp,
    output logic          col_push,
    output logic [31:0]   col,
    input  wire           col_full,
    output logic          val_push,
    output logic [31:0]   val
);

    logic [addr_w-1:0] left;
    logic [addr_w-1:0] index;
    entry_t            entry;

    always_ff @(posedge clk) begin
        // address of the current entry, 8 bytes apart
        entry_req.addr     <= regs.r1 + {index[addr_w-4:0], 3'b000};
        entry_req.d_or_tag <= {61'd0, tag_entry};
        if (reset) begin
            left         <= '0;
            index        <= '0;
            entry_req.ld <= 1'b0;
            entry_req.st <= 1'b0;
        end else begin
            entry_req.ld <= 1'b0;
            entry_req.st <= 1'b0;
            if (run_start) begin
                left  <= regs.r3;
                index <= '0;
            end else if (left != '0 && !req_full && !col_full) begin
                entry_req.ld <= 1'b1;
                left         <= left - 1'b1;
                index        <= index + 1'b1;
            end
        end
    end

    // column goes to the x loader, value to the accumulator
    assign entry = entry_t'(entry_rsp.q);
    assign col_push = entry_rsp.push;
    assign col = entry.col;
    assign val_push = entry_rsp.push;
    assign val = entry.value;

endmodule

`default_nettype wire

//--- rtl/x_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module x_fetch
    import spmv_pkg::*;
    import mem_pkg::*;
(
    input  wire               clk,
    input  wire               reset,
    input  wire pe_regs_t     regs,
    input  wire               col_push,
    input  wire [31:0]        col,
    output logic              col_full,
    output mem_req_t          x_req,
    input  wire               req_full,
    input  wire mem_rsp_t     x_rsp,
    input  wire               x_pop,
    output logic [data_w-1:0] x_q,
    output logic              x_empty,
    output logic              x_almost_full
);

    logic        col_pop;
    logic        col_valid;
    logic        col_empty;
    logic        col_af;
    logic [31:0] col_q;

    sync_fifo #(
        .width(32), .depth(queue_depth), .almost_full_count(queue_almost_full)
    ) u_col_q (
        .clk, .reset, .push(col_push), .pop(col_pop), .d(col), .q(col_q),
        .full(), .empty(col_empty), .almost_full(col_af)
    );

    assign col_pop = !col_empty && !req_full;

    always_ff @(posedge clk) begin
        if (reset) begin
            col_valid <= 1'b0;
            col_full  <= 1'b0;
        end else begin
            col_valid <= col_pop;
            col_full  <= col_af;
        end
    end

    // col_q is valid the cycle after its pop
    always_comb begin
        x_req.ld       = col_valid;
        x_req.st       = 1'b0;
        x_req.addr     = regs.r2 + addr_w'({col_q, 3'b000});
        x_req.d_or_tag = {61'd0, tag_x};
    end

    // returned x words wait here for their values
    sync_fifo #(
        .width(data_w), .depth(queue_depth), .almost_full_count(queue_almost_full)
    ) u_x_q (
        .clk, .reset, .push(x_rsp.push), .pop(x_pop), .d(x_rsp.q), .q(x_q),
        .full(), .empty(x_empty), .almost_full(x_almost_full)
    );

endmodule

`default_nettype wire

//--- rtl/dot_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module dot_accumulator
    import spmv_pkg::*;
    import mem_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              run_start,
    input  wire pe_regs_t    regs,
    input  wire              val_push,
    input  wire [31:0]       val,
    output logic             val_almost_full,
    input  wire [data_w-1:0] x_q,
    input  wire              x_empty,
    output logic             x_pop,
    output mem_req_t         store_req,
    input  wire              req_full
);

    logic                     val_empty;
    logic [31:0]              val_q;
    logic                     pair_valid;
    logic                     active;
    logic [addr_w-1:0]        pops_left;
    logic signed [data_w-1:0] val_ext;
    logic signed [data_w-1:0] product;
    logic signed [data_w-1:0] sum;

    sync_fifo #(
        .width(32), .depth(queue_depth), .almost_full_count(queue_almost_full)
    ) u_val_q (
        .clk, .reset, .push(val_push), .pop(x_pop), .d(val), .q(val_q),
        .full(), .empty(val_empty), .almost_full(val_almost_full)
    );

    // value and x word leave their queues together
    assign x_pop = active && pops_left != '0 && !val_empty && !x_empty;
    assign val_ext = {{(data_w - 32){val_q[31]}}, val_q};
    assign product = val_ext * $signed(x_q);

    always_ff @(posedge clk) begin
        store_req.addr     <= regs.r0;
        store_req.d_or_tag <= sum;
        if (reset) begin
            active       <= 1'b0;
            pops_left    <= '0;
            pair_valid   <= 1'b0;
            store_req.ld <= 1'b0;
            store_req.st <= 1'b0;
        end else begin
            store_req.ld <= 1'b0;
            store_req.st <= 1'b0;
            pair_valid   <= x_pop;
            if (run_start) begin
                active    <= 1'b1;
                pops_left <= regs.r3;
                sum       <= '0;
            end else begin
                if (x_pop)
                    pops_left <= pops_left - 1'b1;
                if (pair_valid)
                    sum <= sum + product;
                // last product is in the sum once the pipe is empty
                if (active && pops_left == '0 && !pair_valid && !req_full) begin
                    store_req.st <= 1'b1;
                    active       <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter
    import mem_pkg::*;
(
    input  wire           clk,
    input  wire           reset,
    input  wire mem_req_t store_req,
    input  wire mem_req_t x_req,
    input  wire mem_req_t entry_req,
    output logic          store_full,
    output logic          x_full,
    output logic          entry_full,
    output mem_req_t      mem_req,
    input  wire           req_stall,
    input  wire mem_rsp_t rsp,
    output mem_rsp_t      x_rsp,
    output mem_rsp_t      entry_rsp,
    input  wire           x_almost_full,
    input  wire           val_almost_full,
    output logic          rsp_stall,
    output logic          run_done
);

    localparam int req_w = $bits(mem_req_t);

    mem_req_t   src_d [3];
    mem_req_t   src_q [3];
    logic [2:0] src_push;
    logic [2:0] src_pop;
    logic [2:0] src_empty;
    logic [2:0] src_af;
    logic [2:0] src_full_r;
    req_src_t   sel;
    req_src_t   sel_r;
    mem_req_t   staged;
    mem_req_t   shared_q;
    logic       shared_empty;
    logic       shared_af;
    logic       shared_pop;
    logic       port_valid;
    logic       req_stall_r;
    mem_rsp_t   rsp_r;

    // slot 0 store, 1 x, 2 entry
    assign src_d[0] = store_req;
    assign src_d[1] = x_req;
    assign src_d[2] = entry_req;

    for (genvar i = 0; i < 3; i++) begin : g_src
        assign src_push[i] = src_d[i].ld || src_d[i].st;
        sync_fifo #(
            .width(req_w), .depth(queue_depth), .almost_full_count(queue_almost_full)
        ) u_src_q (
            .clk, .reset, .push(src_push[i]), .pop(src_pop[i]), .d(src_d[i]),
            .q(src_q[i]), .full(), .empty(src_empty[i]), .almost_full(src_af[i])
        );
    end

    // fixed priority, nothing while the shared queue is nearly full
    always_comb begin
        sel = SRC_NONE;
        if (!shared_af) begin
            if (!src_empty[0])
                sel = SRC_STORE;
            else if (!src_empty[1])
                sel = SRC_X;
            else if (!src_empty[2])
                sel = SRC_ENTRY;
        end
    end

    assign src_pop = {sel == SRC_ENTRY, sel == SRC_X, sel == SRC_STORE};

    always_comb begin
        case (sel_r)
            SRC_STORE: staged = src_q[0];
            SRC_X:     staged = src_q[1];
            SRC_ENTRY: staged = src_q[2];
            default:   staged = '0;
        endcase
    end

    sync_fifo #(
        .width(req_w), .depth(queue_depth), .almost_full_count(queue_almost_full)
    ) u_shared_q (
        .clk, .reset, .push(sel_r != SRC_NONE), .pop(shared_pop), .d(staged),
        .q(shared_q), .full(), .empty(shared_empty), .almost_full(shared_af)
    );

    assign shared_pop = !shared_empty && !req_stall_r;

    always_ff @(posedge clk) begin
        rsp_r.tag <= rsp.tag;
        rsp_r.q   <= rsp.q;
        if (reset) begin
            sel_r       <= SRC_NONE;
            port_valid  <= 1'b0;
            req_stall_r <= 1'b0;
            src_full_r  <= '0;
            rsp_r.push  <= 1'b0;
            rsp_stall   <= 1'b0;
        end else begin
            sel_r       <= sel;
            port_valid  <= shared_pop;
            req_stall_r <= req_stall;
            src_full_r  <= src_af;
            rsp_r.push  <= rsp.push;
            rsp_stall   <= x_almost_full || val_almost_full;
        end
    end

    // popped entry is on the port the cycle after its pop
    always_comb begin
        mem_req    = shared_q;
        mem_req.ld = port_valid && shared_q.ld;
        mem_req.st = port_valid && shared_q.st;
    end

    assign run_done = port_valid && shared_q.st;

    assign store_full = src_full_r[0];
    assign x_full = src_full_r[1];
    assign entry_full = src_full_r[2];

    always_comb begin
        x_rsp          = rsp_r;
        x_rsp.push     = rsp_r.push && rsp_r.tag[tag_x_bit];
        entry_rsp      = rsp_r;
        entry_rsp.push = rsp_r.push && !rsp_r.tag[tag_x_bit];
    end

endmodule

`default_nettype wire

//--- rtl/spmv_pe.sv
`timescale 1ns/10ps
`default_nettype none

module spmv_pe
    import spmv_pkg::*;
    import mem_pkg::*;
#(
    parameter logic [3:0] pe_id = 4'd0
) (
    input  wire           clk,
    input  wire           reset,
    input  wire ring_op_t op_in,
    output ring_op_t      op_out,
    input  wire           busy_in,
    output logic          busy_out,
    output mem_req_t      mem_req,
    input  wire           req_stall,
    input  wire mem_rsp_t rsp,
    output logic          rsp_stall
);

    pe_regs_t          regs;
    logic              run_start;
    logic              run_done;
    mem_req_t          store_req;
    mem_req_t          x_req;
    mem_req_t          entry_req;
    logic              store_full;
    logic              x_full;
    logic              entry_full;
    mem_rsp_t          x_rsp;
    mem_rsp_t          entry_rsp;
    logic              col_push;
    logic [31:0]       col;
    logic              col_full;
    logic              val_push;
    logic [31:0]       val;
    logic              val_almost_full;
    logic [data_w-1:0] x_q;
    logic              x_pop;
    logic              x_empty;
    logic              x_almost_full;

    op_ring_ctrl #(.pe_id(pe_id)) u_ring (
        .clk, .reset, .op_in, .op_out, .busy_in, .busy_out, .regs, .run_start, .run_done
    );

    entry_fetch u_entry (
        .clk, .reset, .run_start, .regs, .entry_req, .req_full(entry_full), .entry_rsp,
        .col_push, .col, .col_full, .val_push, .val
    );

    x_fetch u_x (
        .clk, .reset, .regs, .col_push, .col, .col_full, .x_req, .req_full(x_full),
        .x_rsp, .x_pop, .x_q, .x_empty, .x_almost_full
    );

    dot_accumulator u_acc (
        .clk, .reset, .run_start, .regs, .val_push, .val, .val_almost_full, .x_q,
        .x_empty, .x_pop, .store_req, .req_full(store_full)
    );

    mem_arbiter u_arb (
        .clk, .reset, .store_req, .x_req, .entry_req, .store_full, .x_full, .entry_full,
        .mem_req, .req_stall, .rsp, .x_rsp, .entry_rsp, .x_almost_full, .val_almost_full,
        .rsp_stall, .run_done
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset released on a rising edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/spmv_pe_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module spmv_pe_asserts
    import spmv_pkg::*;
    import mem_pkg::*;
(
    input wire           clk,
    input wire           reset,
    input wire mem_req_t mem_req,
    input wire           req_stall,
    input wire ring_op_t op_out,
    input wire           busy_out
);

    logic stall_r;
    int   failures = 0;

    // same registered stall the arbiter uses
    always_ff @(posedge clk) begin
        if (reset)
            stall_r <= 1'b0;
        else
            stall_r <= req_stall;
    end

    ld_st_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.ld && mem_req.st))
        else begin
            failures++;
            $error("ld and st high in the same cycle");
        end

    port_quiet_in_reset: assert property (@(posedge clk)
        reset |=> !(mem_req.ld || mem_req.st))
        else begin
            failures++;
            $error("memory request during reset");
        end

    // request leaving one cycle after a pop under registered stall
    no_req_under_stall: assert property (@(posedge clk) disable iff (reset)
        $past(stall_r) |-> !(mem_req.ld || mem_req.st))
        else begin
            failures++;
            $error("memory request while the registered stall was high");
        end

    ring_idle_after_reset: assert property (@(posedge clk)
        reset |=> (op_out.opcode == OP_NOP && !busy_out))
        else begin
            failures++;
            $error("ring output not idle after reset");
        end

endmodule

bind spmv_pe spmv_pe_asserts u_asserts (
    .clk(clk), .reset(reset), .mem_req(mem_req), .req_stall(req_stall),
    .op_out(op_out), .busy_out(busy_out)
);

`default_nettype wire

//--- sim/spmv_pe_tb.sv
`timescale 1ns/10ps
`default_nettype none

module spmv_pe_tb
    import spmv_pkg::*;
    import mem_pkg::*;
();

    localparam int nnz = 8;
    localparam int runs = 2;
    localparam int watchdog_cycles = 200 * nnz * runs + 2000;
    localparam logic [47:0] res_base = 48'h4_0000;
    localparam logic [47:0] ent_base = 48'h1000;
    localparam logic [47:0] x_base = 48'h8000;

    logic        clk;
    logic        reset;
    ring_op_t    op_in = '0;
    ring_op_t    op_out;
    logic        busy_in = 1'b0;
    logic        busy_out;
    mem_req_t    mem_req;
    logic        req_stall = 1'b0;
    mem_rsp_t    rsp = '0;
    logic        rsp_stall;
    logic [63:0] mem_data [logic [47:0]];
    int          pend_due [$];
    mem_rsp_t    pend_rsp [$];
    integer      seed = 50;
    int          cycle = 0;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          store_count = 0;
    logic        stall_on = 1'b0;
    string       test_name = "reset";
    logic [63:0] exp_sum = '0;
    logic [47:0] exp_addr = '0;

    tb_clock u_clock (.clk(clk), .reset(reset));

    spmv_pe #(.pe_id(4'd3)) dut (
        .clk(clk), .reset(reset), .op_in(op_in), .op_out(op_out), .busy_in(busy_in),
        .busy_out(busy_out), .mem_req(mem_req), .req_stall(req_stall), .rsp(rsp),
        .rsp_stall(rsp_stall)
    );

    // unwritten words still differ per address
    function automatic logic [63:0] read_word(input logic [47:0] addr);
        if (mem_data.exists(addr))
            return mem_data[addr];
        return {addr[15:0], addr} ^ 64'h5bd1_e995_0f1e_2d3c;
    endfunction

    // expected row dot product from memory and register values
    function automatic logic [63:0] ref_dot(input logic [47:0] r1, input logic [47:0] r2,
                                            input logic [47:0] r3);
        logic signed [63:0] sum;
        logic signed [63:0] v;
        entry_t             e;
        sum = '0;
        for (int i = 0; i < int'(r3); i++) begin
            e = entry_t'(read_word(r1 + 48'(i * 8)));
            v = {{32{e.value[31]}}, e.value};
            sum = sum + v * $signed(read_word(r2 + 48'({e.col, 3'b000})));
        end
        return sum;
    endfunction

    function automatic ring_op_t make_op(input opcode_t opc, input logic [3:0] id,
                                         input logic bcast, input logic [3:0] idx,
                                         input logic [51:0] data);
        return '{data: data, reg_idx: idx, broadcast: bcast, pe_id: id, opcode: opc};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, expected,
                     actual);
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: failed", test_name);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    // one op on the ring, then idle
    task automatic send_op(input ring_op_t op);
        @(posedge clk);
        op_in <= op;
        @(posedge clk);
        op_in <= '0;
    endtask

    // latency counted from the edge that drove op_in
    task automatic expect_ring(input int latency, input ring_op_t expected, input string what);
        repeat (latency - 1) @(posedge clk);
        @(negedge clk);
        check_value(what, expected, op_out);
    endtask

    task automatic load_reg(input logic [3:0] idx, input logic [47:0] value, input logic bcast);
        send_op(make_op(OP_LD, bcast ? 4'd0 : 4'd3, bcast, idx, {4'd0, value}));
    endtask

    task automatic fill_matrix(input logic [47:0] r1, input logic [47:0] r2);
        logic [31:0] col;
        logic [31:0] value;
        for (int i = 0; i < nnz; i++) begin
            col = $unsigned($random(seed)) % 64;
            value = $random(seed);
            mem_data[r1 + 48'(i * 8)] = {value, col};
        end
        for (int c = 0; c < 64; c++)
            mem_data[r2 + 48'(c * 8)] = {$random(seed), $random(seed)};
    endtask

    task automatic run_spmv(input string name, input logic stall);
        int first;
        int waited;
        begin_test(name);
        stall_on = stall;
        fill_matrix(ent_base, x_base);
        load_reg(4'd0, res_base, 1'b0);
        load_reg(4'd1, ent_base, 1'b0);
        load_reg(4'd2, x_base, 1'b0);
        load_reg(4'd3, 48'(nnz), 1'b0);
        exp_addr = res_base;
        exp_sum = ref_dot(ent_base, x_base, 48'(nnz));
        first = store_count + 1;
        send_op(make_op(OP_STEADY, 4'd3, 1'b0, 4'd0, 52'd0));
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("busy_out during run", 64'd1, 64'(busy_out));
        waited = 0;
        while (store_count < first && waited < 200 * nnz) begin
            @(negedge clk);
            waited++;
        end
        if (store_count < first) begin
            errors++;
            $display("%s: no store arrived within %0d cycles", name, waited);
        end
        repeat (4) @(negedge clk);
        check_value("busy_out after store", 64'd0, 64'(busy_out));
        // both response queues are drained by now
        check_value("rsp_stall after store", 64'd0, 64'(rsp_stall));
        // a second store would show up here
        repeat (30) @(negedge clk);
        check_value("store count", 64'(first), 64'(store_count));
        stall_on = 1'b0;
        end_test();
    endtask

    // memory model, in-order answers after a random delay
    always @(posedge clk) begin : mem_model
        int       delay;
        mem_rsp_t next_rsp;
        if (reset) begin
            rsp <= '0;
            req_stall <= 1'b0;
        end else begin
            cycle++;
            if (mem_req.st)
                mem_data[mem_req.addr] = mem_req.d_or_tag;
            if (mem_req.ld) begin
                delay = 2 + int'($unsigned($random(seed)) % 8);
                next_rsp.push = 1'b1;
                next_rsp.tag = mem_req.d_or_tag[2:0];
                next_rsp.q = read_word(mem_req.addr);
                pend_due.push_back(cycle + delay);
                pend_rsp.push_back(next_rsp);
            end
            rsp <= '0;
            if (pend_due.size() > 0 && pend_due[0] <= cycle && !rsp_stall) begin
                rsp <= pend_rsp.pop_front();
                void'(pend_due.pop_front());
            end
            req_stall <= stall_on && ($unsigned($random(seed)) % 4 == 0);
        end
    end

    // every store is compared against the reference
    always @(posedge clk) begin
        if (!reset && mem_req.st) begin
            store_count++;
            check_value("store addr", 64'(exp_addr), 64'(mem_req.addr));
            check_value("store data", exp_sum, mem_req.d_or_tag);
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run still going after %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [47:0] vals [4];
        ring_op_t    other;
        do
            @(posedge clk);
        while (reset);

        begin_test("ring pass-through");
        other = make_op(OP_LD, 4'd5, 1'b0, 4'd1, 52'h1_2345_6789);
        send_op(other);
        @(negedge clk);
        check_value("op_out after 1 cycle", 64'd0, op_out);
        expect_ring(2, other, "op_out after 2 cycles");
        @(posedge clk);
        busy_in <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_value("busy_out after 1 cycle", 64'd0, 64'(busy_out));
        @(posedge clk);
        @(negedge clk);
        check_value("busy_out after 2 cycles", 64'd1, 64'(busy_out));
        @(posedge clk);
        busy_in <= 1'b0;
        repeat (4) @(posedge clk);
        end_test();

        // r3 goes in by broadcast
        begin_test("register load and read");
        for (int i = 0; i < 4; i++) begin
            vals[i] = 48'({$random(seed), $random(seed)});
            load_reg(4'(i), vals[i], i == 3);
        end
        for (int i = 0; i < 4; i++) begin
            send_op(make_op(OP_READ, 4'd3, 1'b0, 4'(i), 52'd0));
            expect_ring(3, make_op(OP_RETURN, 4'd3, 1'b0, 4'(i), {4'd0, vals[i]}),
                        "read return");
        end
        end_test();

        run_spmv("steady run", 1'b0);
        run_spmv("run under stall", 1'b1);

        begin_test("register reset");
        send_op(make_op(OP_RST, 4'd3, 1'b0, 4'd0, 52'd0));
        for (int i = 0; i < 4; i++) begin
            send_op(make_op(OP_READ, 4'd3, 1'b0, 4'(i), 52'd0));
            expect_ring(3, make_op(OP_RETURN, 4'd3, 1'b0, 4'(i), 52'd0), "read after reset");
        end
        end_test();

        errors += dut.u_asserts.failures;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut.u_asserts.failures);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
rtl/spmv_pkg.sv
rtl/mem_pkg.sv
rtl/sync_fifo.sv
rtl/op_ring_ctrl.sv
rtl/entry_fetch.sv
rtl/x_fetch.sv
rtl/dot_accumulator.sv
rtl/mem_arbiter.sv
rtl/spmv_pe.sv
sim/tb_clock.sv
sim/spmv_pe_asserts.sv
sim/spmv_pe_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= spmv_pe_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
